/* hw/lc4_pkg.sv */
package lc4_pkg;

    // ISA widths
    localparam int word_w    = 16;
    localparam int reg_sel_w = 3;
    localparam int nzp_w     = 3;

    // first fetch address after reset
    localparam logic [word_w-1:0] reset_pc = 16'h8200;

    // opcodes in insn[15:12]
    localparam logic [3:0] op_br    = 4'b0000;
    localparam logic [3:0] op_arith = 4'b0001;
    localparam logic [3:0] op_logic = 4'b0101;
    localparam logic [3:0] op_ldr   = 4'b0110;
    localparam logic [3:0] op_str   = 4'b0111;
    localparam logic [3:0] op_const = 4'b1001;

    // sub-op codes in insn[5:3], arith group
    localparam logic [2:0] fn_add = 3'b000;
    localparam logic [2:0] fn_sub = 3'b010;
    // sub-op codes in insn[5:3], logic group
    localparam logic [2:0] fn_and = 3'b000;
    localparam logic [2:0] fn_or  = 3'b010;
    localparam logic [2:0] fn_xor = 3'b011;

    typedef struct packed {
        logic [3:0]           opcode;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] rs;
        logic [2:0]           sub;
        logic [reg_sel_w-1:0] rt;
    } insn_rrr_t;

    // imm_flag and imm5 together also form imm6 of LDR and STR
    typedef struct packed {
        logic [3:0]           opcode;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] rs;
        logic                 imm_flag;
        logic [4:0]           imm5;
    } insn_imm_t;

    typedef struct packed {
        logic [3:0]       opcode;
        logic [nzp_w-1:0] nzp;
        logic [8:0]       imm9;
    } insn_br_t;

    typedef union packed {
        insn_rrr_t rrr;
        insn_imm_t imm;
        insn_br_t  br;
    } insn_u;

    typedef struct packed {
        logic [reg_sel_w-1:0] rs_sel;
        logic [reg_sel_w-1:0] rt_sel;
        logic [reg_sel_w-1:0] rd_sel;
        logic                 rs_re;
        logic                 rt_re;
        logic                 rd_we;
        logic                 nzp_we;
        logic                 is_load;
        logic                 is_store;
        logic                 is_branch;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [word_w-1:0] pc;
        insn_u             insn;
        ctrl_t             ctrl;
    } stage_t;

    typedef enum logic [1:0] {
        none   = 2'd0,
        from_m = 2'd1,
        from_w = 2'd2
    } bypass_sel_e;

    typedef struct packed {
        logic                 valid;
        logic [word_w-1:0]    pc;
        insn_u                insn;
        logic                 rf_we;
        logic [reg_sel_w-1:0] rf_wsel;
        logic [word_w-1:0]    rf_wdata;
        logic                 nzp_we;
        logic [nzp_w-1:0]     nzp_bits;
        logic                 dm_we;
        logic [word_w-1:0]    dm_addr;
        logic [word_w-1:0]    dm_data;
    } wb_trace_t;

endpackage

/* hw/lc4_decoder.sv */
`timescale 1ns/1ns

module lc4_decoder import lc4_pkg::*; (
    input  insn_u i_insn,
    output ctrl_t o_ctrl
);

    // register-register sub-op supported for this opcode group
    logic rr_ok;
    // instruction of the arith/logic groups that writes a register
    logic alu_ok;

    assign rr_ok = (i_insn.rrr.opcode == op_arith) ?
                   (i_insn.rrr.sub == fn_add || i_insn.rrr.sub == fn_sub) :
                   (i_insn.rrr.sub == fn_and || i_insn.rrr.sub == fn_or ||
                    i_insn.rrr.sub == fn_xor);

    // ADD imm5 and AND imm5 are both legal
    assign alu_ok = i_insn.imm.imm_flag || rr_ok;

    always_comb begin
        o_ctrl = '0;
        o_ctrl.rs_sel = i_insn.rrr.rs;
        // a store reads its data register from the rd field
        o_ctrl.rt_sel = (i_insn.rrr.opcode == op_str) ? i_insn.rrr.rd : i_insn.rrr.rt;
        o_ctrl.rd_sel = i_insn.rrr.rd;

        case (i_insn.rrr.opcode)
            op_br: begin
                // nzp of 000 never branches
                o_ctrl.is_branch = (i_insn.br.nzp != '0);
            end
            op_arith, op_logic: begin
                o_ctrl.rs_re  = alu_ok;
                o_ctrl.rt_re  = alu_ok && !i_insn.imm.imm_flag;
                o_ctrl.rd_we  = alu_ok;
                o_ctrl.nzp_we = alu_ok;
            end
            op_ldr: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            op_str: begin
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            op_const: begin
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            default: begin
                // anything else retires as a no-op
                o_ctrl.rs_re = 1'b0;
            end
        endcase
    end

endmodule

/* hw/lc4_alu.sv */
`timescale 1ns/1ns

module lc4_alu import lc4_pkg::*; (
    input  insn_u             i_insn,
    input  logic [word_w-1:0] i_pc,
    input  logic [word_w-1:0] i_rs,
    input  logic [word_w-1:0] i_rt,
    output logic [word_w-1:0] o_result
);

    logic [word_w-1:0] imm5_sx;
    logic [word_w-1:0] imm6_sx;
    logic [word_w-1:0] imm9_sx;
    logic [word_w-1:0] arith_res;
    logic [word_w-1:0] logic_res;

    assign imm5_sx = {{(word_w-5){i_insn.imm.imm5[4]}}, i_insn.imm.imm5};
    // imm6 spans the flag bit and imm5
    assign imm6_sx = {{(word_w-6){i_insn.imm.imm_flag}}, i_insn.imm.imm_flag, i_insn.imm.imm5};
    assign imm9_sx = {{(word_w-9){i_insn.br.imm9[8]}}, i_insn.br.imm9};

    always_comb begin
        if (i_insn.imm.imm_flag) begin
            arith_res = i_rs + imm5_sx;
        end else if (i_insn.rrr.sub == fn_sub) begin
            arith_res = i_rs - i_rt;
        end else begin
            arith_res = i_rs + i_rt;
        end
    end

    always_comb begin
        if (i_insn.imm.imm_flag) begin
            logic_res = i_rs & imm5_sx;
        end else begin
            case (i_insn.rrr.sub)
                fn_and:  logic_res = i_rs & i_rt;
                fn_or:   logic_res = i_rs | i_rt;
                fn_xor:  logic_res = i_rs ^ i_rt;
                default: logic_res = '0;
            endcase
        end
    end

    always_comb begin
        case (i_insn.rrr.opcode)
            op_arith:       o_result = arith_res;
            op_logic:       o_result = logic_res;
            op_const:       o_result = imm9_sx;
            // effective address
            op_ldr, op_str: o_result = i_rs + imm6_sx;
            // branch target
            op_br:          o_result = i_pc + 16'd1 + imm9_sx;
            default:        o_result = '0;
        endcase
    end

endmodule

/* hw/lc4_regfile.sv */
`timescale 1ns/1ns

module lc4_regfile import lc4_pkg::*; (
    input  logic                 gwe,
    input  logic                 i_arst_n,
    input  logic [reg_sel_w-1:0] i_rs_sel,
    input  logic [reg_sel_w-1:0] i_rt_sel,
    input  logic [reg_sel_w-1:0] i_rd_sel,
    input  logic                 i_we,
    input  logic [word_w-1:0]    i_wdata,
    output logic [word_w-1:0]    o_rs_data,
    output logic [word_w-1:0]    o_rt_data
);

    logic [word_w-1:0] regs [2**reg_sel_w];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**reg_sel_w; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // write-before-read, so decode sees the value retiring this cycle
    assign o_rs_data = (i_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

/* hw/lc4_hazard_unit.sv */
`timescale 1ns/1ns

module lc4_hazard_unit import lc4_pkg::*; (
    input  stage_t      i_d,
    input  stage_t      i_x,
    input  stage_t      i_m,
    input  stage_t      i_w,
    output bypass_sel_e o_rs_sel,
    output bypass_sel_e o_rt_sel,
    output logic        o_store_from_w,
    output logic        o_load_stall
);

    logic rs_uses_x;
    logic rt_uses_x;

    // true when an older stage will write the given register
    function automatic logic writes(input stage_t s, input logic [reg_sel_w-1:0] sel);
        return s.valid && s.ctrl.rd_we && s.ctrl.rd_sel == sel;
    endfunction

    // M is younger than W, so its value wins
    function automatic bypass_sel_e pick(input logic re, input logic [reg_sel_w-1:0] sel,
                                         input stage_t m, input stage_t w);
        bypass_sel_e res;
        res = none;
        if (re && writes(m, sel)) begin
            res = from_m;
        end else if (re && writes(w, sel)) begin
            res = from_w;
        end
        return res;
    endfunction

    assign o_rs_sel = pick(i_x.ctrl.rs_re, i_x.ctrl.rs_sel, i_m, i_w);
    assign o_rt_sel = pick(i_x.ctrl.rt_re, i_x.ctrl.rt_sel, i_m, i_w);

    // store data picked up from the retiring instruction
    assign o_store_from_w = i_m.valid && i_m.ctrl.is_store && writes(i_w, i_m.ctrl.rt_sel);

    assign rs_uses_x = i_d.ctrl.rs_re && writes(i_x, i_d.ctrl.rs_sel);
    // store data is left out, the WM path delivers it in time
    assign rt_uses_x = i_d.ctrl.rt_re && !i_d.ctrl.is_store && writes(i_x, i_d.ctrl.rt_sel);

    assign o_load_stall = i_d.valid && i_x.ctrl.is_load && (rs_uses_x || rt_uses_x);

endmodule

/* hw/lc4_processor.sv */
`timescale 1ns/1ns

module lc4_processor import lc4_pkg::*; (
    input  logic              gwe,
    input  logic              i_arst_n,
    output logic [word_w-1:0] o_cur_pc,
    input  logic [word_w-1:0] i_cur_insn,
    output logic [word_w-1:0] o_dmem_addr,
    input  logic [word_w-1:0] i_dmem_rdata,
    output logic              o_dmem_we,
    output logic [word_w-1:0] o_dmem_wdata,
    output wb_trace_t         o_trace
);

    logic [word_w-1:0] pc;
    logic              d_valid;
    logic [word_w-1:0] d_pc;
    insn_u             d_insn;
    ctrl_t             d_ctrl;
    stage_t            d_stage;
    stage_t            x_stage;
    stage_t            m_stage;
    stage_t            w_stage;

    logic [word_w-1:0] rf_rs_data;
    logic [word_w-1:0] rf_rt_data;
    logic [word_w-1:0] x_rs;
    logic [word_w-1:0] x_rt;
    logic [word_w-1:0] x_rs_fwd;
    logic [word_w-1:0] x_rt_fwd;
    logic [word_w-1:0] x_result;
    bypass_sel_e       rs_byp;
    bypass_sel_e       rt_byp;
    logic              store_from_w;
    logic              load_stall;
    logic              x_taken;

    logic [nzp_w-1:0]  nzp_reg;
    logic [nzp_w-1:0]  nzp_cur;
    logic [nzp_w-1:0]  m_nzp;
    logic [nzp_w-1:0]  w_nzp;
    logic [word_w-1:0] m_result;
    logic [word_w-1:0] m_rt;
    logic [word_w-1:0] m_wdata;
    logic [word_w-1:0] m_dm_data;
    logic [word_w-1:0] w_wdata;
    logic [word_w-1:0] w_dm_addr;
    logic [word_w-1:0] w_dm_data;

    function automatic logic [nzp_w-1:0] nzp_of(input logic [word_w-1:0] value);
        logic [nzp_w-1:0] bits;
        if (value[word_w-1]) begin
            bits = 3'b100;
        end else if (value == '0) begin
            bits = 3'b010;
        end else begin
            bits = 3'b001;
        end
        return bits;
    endfunction

    lc4_decoder u_decoder (
        .i_insn (d_insn),
        .o_ctrl (d_ctrl)
    );

    // a bubble in D carries no control bits downstream
    always_comb begin
        d_stage.valid = d_valid;
        d_stage.pc    = d_pc;
        d_stage.insn  = d_insn;
        d_stage.ctrl  = d_valid ? d_ctrl : '0;
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (d_stage.ctrl.rs_sel),
        .i_rt_sel  (d_stage.ctrl.rt_sel),
        .i_rd_sel  (w_stage.ctrl.rd_sel),
        .i_we      (w_stage.valid && w_stage.ctrl.rd_we),
        .i_wdata   (w_wdata),
        .o_rs_data (rf_rs_data),
        .o_rt_data (rf_rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_d            (d_stage),
        .i_x            (x_stage),
        .i_m            (m_stage),
        .i_w            (w_stage),
        .o_rs_sel       (rs_byp),
        .o_rt_sel       (rt_byp),
        .o_store_from_w (store_from_w),
        .o_load_stall   (load_stall)
    );

    // MX and WX bypass
    assign x_rs_fwd = (rs_byp == from_m) ? m_result : (rs_byp == from_w) ? w_wdata : x_rs;
    assign x_rt_fwd = (rt_byp == from_m) ? m_result : (rt_byp == from_w) ? w_wdata : x_rt;

    lc4_alu u_alu (
        .i_insn   (x_stage.insn),
        .i_pc     (x_stage.pc),
        .i_rs     (x_rs_fwd),
        .i_rt     (x_rt_fwd),
        .o_result (x_result)
    );

    // the NZP produced in M is not in the register yet
    assign nzp_cur = m_stage.ctrl.nzp_we ? m_nzp : nzp_reg;
    assign x_taken = x_stage.valid && x_stage.ctrl.is_branch &&
                     ((x_stage.insn.br.nzp & nzp_cur) != '0);

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= reset_pc;
            d_valid <= 1'b0;
            d_pc    <= '0;
            d_insn  <= '0;
        end else if (x_taken) begin
            pc      <= x_result;
            d_valid <= 1'b0;
        end else if (!load_stall) begin
            pc      <= pc + 16'd1;
            d_valid <= 1'b1;
            d_pc    <= pc;
            d_insn  <= i_cur_insn;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            x_stage <= '0;
            m_stage <= '0;
            w_stage <= '0;
            nzp_reg <= '0;
        end else begin
            // bubble into X on a load-use stall or a taken branch
            x_stage <= (x_taken || load_stall) ? '0 : d_stage;
            m_stage <= x_stage;
            w_stage <= m_stage;
            if (m_stage.ctrl.nzp_we) begin
                nzp_reg <= m_nzp;
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs      <= rf_rs_data;
        x_rt      <= rf_rt_data;
        m_result  <= x_result;
        m_rt      <= x_rt_fwd;
        w_wdata   <= m_wdata;
        w_nzp     <= m_nzp;
        w_dm_addr <= (m_stage.ctrl.is_load || m_stage.ctrl.is_store) ? m_result : '0;
        w_dm_data <= m_dm_data;
    end

    assign m_wdata = m_stage.ctrl.is_load ? i_dmem_rdata : m_result;
    assign m_nzp   = nzp_of(m_wdata);

    assign o_cur_pc     = pc;
    assign o_dmem_addr  = m_result;
    assign o_dmem_we    = m_stage.valid && m_stage.ctrl.is_store;
    // WM bypass of store data
    assign o_dmem_wdata = store_from_w ? w_wdata : m_rt;
    assign m_dm_data    = m_stage.ctrl.is_load  ? i_dmem_rdata :
                          m_stage.ctrl.is_store ? o_dmem_wdata : '0;

    always_comb begin
        o_trace.valid    = w_stage.valid;
        o_trace.pc       = w_stage.pc;
        o_trace.insn     = w_stage.insn;
        o_trace.rf_we    = w_stage.ctrl.rd_we;
        o_trace.rf_wsel  = w_stage.ctrl.rd_sel;
        o_trace.rf_wdata = w_wdata;
        o_trace.nzp_we   = w_stage.ctrl.nzp_we;
        o_trace.nzp_bits = w_nzp;
        o_trace.dm_we    = w_stage.ctrl.is_store;
        o_trace.dm_addr  = w_dm_addr;
        o_trace.dm_data  = w_dm_data;
    end

endmodule

/* tests/lc4_isa_model.svh */
`ifndef LC4_ISA_MODEL_SVH
`define LC4_ISA_MODEL_SVH

// architectural state of the in-order reference
logic [15:0] ref_regs [8];
logic [2:0]  ref_nzp;
logic [15:0] ref_pc;
logic [15:0] ref_mem [logic [15:0]];

// words outside the program region read as zero, a no-op
function automatic logic [15:0] fetch_word(input logic [15:0] addr);
    logic [15:0] off;
    off = addr - reset_pc;
    return (off < 16'd256) ? imem[off[7:0]] : 16'h0000;
endfunction

// low width bits of raw taken as a two's complement field
function automatic logic [15:0] sign_extend(input logic [15:0] raw, input int width);
    logic [15:0] shifted;
    shifted = raw << (16 - width);
    return $signed(shifted) >>> (16 - width);
endfunction

function automatic logic [2:0] nzp_for(input logic [15:0] value);
    logic [2:0] bits;
    if ($signed(value) < 16'sd0) begin
        bits = 3'b100;
    end else if (value == 16'h0000) begin
        bits = 3'b010;
    end else begin
        bits = 3'b001;
    end
    return bits;
endfunction

task automatic model_reset();
    for (int i = 0; i < 8; i++) begin
        ref_regs[i[2:0]] = 16'h0000;
    end
    ref_nzp = 3'b000;
    ref_pc  = reset_pc;
    ref_mem.delete();
endtask

// executes the instruction at ref_pc and returns what it should retire as
task automatic model_step(output wb_trace_t exp);
    logic [15:0] word;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic [15:0] next_pc;
    logic        wr;
    word    = fetch_word(ref_pc);
    a       = ref_regs[word[8:6]];
    b       = ref_regs[word[2:0]];
    res     = 16'h0000;
    wr      = 1'b0;
    next_pc = ref_pc + 16'd1;
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = ref_pc;
    exp.insn  = word;
    case (word[15:12])
        op_br: begin
            if ((word[11:9] & ref_nzp) != 3'b000) begin
                next_pc = ref_pc + 16'd1 + sign_extend(word, 9);
            end
        end
        op_arith: begin
            wr = 1'b1;
            case (word[5:3])
                3'b000: res = a + b;
                3'b010: res = a - b;
                3'b100, 3'b101, 3'b110, 3'b111: res = a + sign_extend(word, 5);
                default: wr = 1'b0;
            endcase
        end
        op_logic: begin
            wr = 1'b1;
            case (word[5:3])
                3'b000: res = a & b;
                3'b010: res = a | b;
                3'b011: res = a ^ b;
                3'b100, 3'b101, 3'b110, 3'b111: res = a & sign_extend(word, 5);
                default: wr = 1'b0;
            endcase
        end
        op_const: begin
            wr  = 1'b1;
            res = sign_extend(word, 9);
        end
        op_ldr: begin
            wr   = 1'b1;
            addr = a + sign_extend(word, 6);
            res  = ref_mem.exists(addr) ? ref_mem[addr] : 16'h0000;
        end
        op_str: begin
            addr = a + sign_extend(word, 6);
            ref_mem[addr] = ref_regs[word[11:9]];
            exp.dm_we   = 1'b1;
            exp.dm_addr = addr;
            exp.dm_data = ref_regs[word[11:9]];
        end
        default: begin
            wr = 1'b0;
        end
    endcase
    if (wr) begin
        ref_regs[word[11:9]] = res;
        ref_nzp      = nzp_for(res);
        exp.rf_we    = 1'b1;
        exp.rf_wsel  = word[11:9];
        exp.rf_wdata = res;
        exp.nzp_we   = 1'b1;
        exp.nzp_bits = ref_nzp;
    end
    ref_pc = next_pc;
endtask

`endif

/* tests/lc4_tb.sv */
`timescale 1ns/1ns

module lc4_tb import lc4_pkg::*; ();

    localparam int num_records    = 2000;
    localparam int timeout_cycles = 4 * num_records + 50;

    logic              gwe = 1'b0;
    logic              arst_n = 1'b0;
    logic [word_w-1:0] cur_pc;
    logic [word_w-1:0] cur_insn;
    logic [word_w-1:0] dmem_addr;
    logic [word_w-1:0] dmem_rdata;
    logic              dmem_we;
    logic [word_w-1:0] dmem_wdata;
    wb_trace_t         trace;

    // program image at reset_pc, data memory is zero until written
    logic [15:0] imem [256];
    logic [15:0] dmem [65536] = '{default: 16'h0000};
    logic [15:0] pc_off;

    int          rec_count = 0;
    int          cycle_count = 0;
    logic        done = 1'b0;
    logic        prev_dm_we = 1'b0;
    logic [15:0] prev_dm_addr = 16'h0000;
    logic [15:0] prev_dm_data = 16'h0000;

    `include "lc4_isa_model.svh"

    always #4 gwe = ~gwe;

    lc4_processor UUT (
        .gwe          (gwe),
        .i_arst_n     (arst_n),
        .o_cur_pc     (cur_pc),
        .i_cur_insn   (cur_insn),
        .o_dmem_addr  (dmem_addr),
        .i_dmem_rdata (dmem_rdata),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .o_trace      (trace)
    );

    assign pc_off     = cur_pc - reset_pc;
    assign cur_insn   = (pc_off < 16'd256) ? imem[pc_off[7:0]] : 16'h0000;
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // one random word for slot idx, branches only jump forward inside the program
    function automatic logic [15:0] random_insn(input int idx);
        logic [15:0] word;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [2:0]  base;
        int          room;
        // r7 is left alone so most loads and stores share a small window
        rd   = 3'($urandom % 7);
        rs   = 3'($urandom % 8);
        base = ($urandom % 4 == 0) ? rs : 3'd7;
        room = (254 - idx < 12) ? 254 - idx : 12;
        word = 16'($urandom);
        case ($urandom % 16)
            0, 1:    word = {op_arith, rd, rs, 1'b0, word[4], 1'b0, word[2:0]};
            2:       word = {op_arith, rd, rs, 1'b1, word[4:0]};
            3, 4:    word = {op_logic, rd, rs, 1'b0, word[4:3], word[2:0]};
            5:       word = {op_logic, rd, rs, 1'b1, word[4:0]};
            6, 7:    word = {op_const, rd, word[8:0]};
            8, 9:    word = {op_ldr, rd, base, word[5:0]};
            10, 11:  word = {op_str, word[11:9], base, word[5:0]};
            12, 13:  word = {op_br, word[11:9], 9'($urandom % (room + 1))};
            // any opcode, but a raw branch must not leave the program
            14:      word = (word[15:12] == op_br) ? {op_br, 3'b000, word[8:0]} : word;
            default: word = {op_arith, rd, rs, 3'b000, word[2:0]};
        endcase
        return word;
    endfunction

    task automatic build_program();
        // the first CONST sets NZP so the closing branch is always taken
        imem[0] = {op_const, 3'd0, 9'($urandom)};
        for (int i = 1; i < 255; i++) begin
            imem[i[7:0]] = random_insn(i);
        end
        imem[255] = {op_br, 3'b111, 9'h100};
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_record();
        wb_trace_t exp;
        string     tag;
        model_step(exp);
        tag = $sformatf("record %0d", rec_count);
        check_value({tag, " pc"}, exp.pc, trace.pc);
        check_value({tag, " insn"}, exp.insn, trace.insn);
        check_value({tag, " rf_we"}, 16'(exp.rf_we), 16'(trace.rf_we));
        if (exp.rf_we) begin
            check_value({tag, " rf_wsel"}, 16'(exp.rf_wsel), 16'(trace.rf_wsel));
            check_value({tag, " rf_wdata"}, exp.rf_wdata, trace.rf_wdata);
        end
        check_value({tag, " nzp_we"}, 16'(exp.nzp_we), 16'(trace.nzp_we));
        if (exp.nzp_we) begin
            check_value({tag, " nzp_bits"}, 16'(exp.nzp_bits), 16'(trace.nzp_bits));
        end
        check_value({tag, " dm_we"}, 16'(exp.dm_we), 16'(trace.dm_we));
        if (exp.dm_we) begin
            check_value({tag, " dm_addr"}, exp.dm_addr, trace.dm_addr);
            check_value({tag, " dm_data"}, exp.dm_data, trace.dm_data);
        end
        // the memory port carried this instruction one cycle ago, while it sat in M
        check_value({tag, " dmem we"}, 16'(exp.dm_we), 16'(prev_dm_we));
        if (exp.dm_we) begin
            check_value({tag, " dmem addr"}, exp.dm_addr, prev_dm_addr);
            check_value({tag, " dmem wdata"}, exp.dm_data, prev_dm_data);
        end
    endtask

    // outputs come from registers, so mid-cycle sampling sees settled values
    always @(negedge gwe) begin
        if (!arst_n) begin
            model_reset();
            check_value("reset trace valid", 16'h0000, 16'(trace.valid));
            check_value("reset dmem we", 16'h0000, 16'(dmem_we));
            check_value("reset pc", reset_pc, cur_pc);
        end else if (!done) begin
            if (trace.valid) begin
                check_record();
                rec_count++;
                done = (rec_count == num_records);
            end else begin
                // a bubble in W was a bubble in M one cycle earlier
                check_value("bubble dmem we", 16'h0000, 16'(prev_dm_we));
            end
            prev_dm_we   = dmem_we;
            prev_dm_addr = dmem_addr;
            prev_dm_data = dmem_wdata;
        end
    end

    always @(posedge gwe) begin
        if (arst_n) begin
            cycle_count++;
            if (cycle_count > timeout_cycles) begin
                $display("timeout after %0d cycles with %0d of %0d records checked",
                         cycle_count, rec_count, num_records);
                $display("TESTBENCH FAILED");
                $fatal(1, "run did not finish in time");
            end
        end
    end

    initial begin
        void'($urandom(32'h97ae));
        build_program();
        arst_n = 1'b0;
        repeat (8) @(posedge gwe);
        #1 arst_n = 1'b1;
        wait (done);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+tests
hw/lc4_pkg.sv
hw/lc4_decoder.sv
hw/lc4_alu.sv
hw/lc4_regfile.sv
hw/lc4_hazard_unit.sv
hw/lc4_processor.sv
tests/lc4_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the LC4 pipeline testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f list.f --top-module lc4_tb -Mdir obj_dir -o lc4_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lc4_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTBENCH PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
